//--- tb.f
hdl/umi_pkg.sv
hdl/umi_if.sv
hdl/umi_arbiter.sv
hdl/umi_starve_timer.sv
hdl/umi_mux.sv
hdl/umi_combiner.sv
hdl/umi_out_buffer.sv
hdl/umi_combiner_top.sv
verif/umi_combiner_assertions.sv
verif/umi_combiner_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the combiner testbench with Verilator
verilator --binary --timing --assert -f tb.f --top-module umi_combiner_tb -o umi_sim || exit 1
out=$(./obj_dir/umi_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "Test passed" && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }

//--- verif/umi_combiner_tb.sv
// Table-driven check of the combiner at 64/32/64 widths and STARVE_LIMIT 4, model tracks buffer
`timescale 1ns/1ps
`default_nettype none

module umi_combiner_tb;
   localparam int AW = 64;
   localparam int CW = 32;
   localparam int DW = 64;
   localparam int STARVE_LIMIT = 4;
   localparam int drain_limit = 400;  // Cycles allowed to empty the pipe

   typedef struct packed {
      logic [CW-1:0] cmd;
      logic [AW-1:0] dstaddr;
      logic [AW-1:0] srcaddr;
      logic [DW-1:0] data;
   } beat_t;

   // One stimulus row, bit i of each pattern is cycle i of a pass
   typedef struct {
      string       name;
      logic [15:0] resp_offer;  // New response beat queued
      logic [15:0] req_offer;   // New request beat queued
      logic [15:0] out_rdy;
      bit          rnd_rdy;     // Ready from the LFSR instead
      int          reps;        // Passes of 16 cycles
   } row_t;

   logic          clk = 1'b0;
   logic          reset;
   logic          umi_resp_in_valid, umi_req_in_valid, umi_out_valid;
   logic          umi_resp_in_ready, umi_req_in_ready, umi_out_ready;
   logic [CW-1:0] umi_resp_in_cmd, umi_req_in_cmd, umi_out_cmd;
   logic [AW-1:0] umi_resp_in_dstaddr, umi_req_in_dstaddr, umi_out_dstaddr;
   logic [AW-1:0] umi_resp_in_srcaddr, umi_req_in_srcaddr, umi_out_srcaddr;
   logic [DW-1:0] umi_resp_in_data, umi_req_in_data, umi_out_data;

   logic [31:0] lfsr_state = 32'he1a41633;
   beat_t       resp_q[$], req_q[$], exp_q[$];  // Source queues and predicted output
   row_t        rows[6];
   bit          pop_resp, pop_req, relief;      // Model state
   int          lock_g, starve_cnt, buf_cnt;    // Grant 0 none, 1 resp, 2 req
   int          cmp_errors, hs_errors, timeouts, total;

   always #4 clk = ~clk;

   umi_combiner_top #(.AW(AW), .CW(CW), .DW(DW), .STARVE_LIMIT(STARVE_LIMIT))
      umi_combiner_top_inst (.*);

   // Fibonacci taps 32,22,2,1, one step per bit
   function automatic logic [63:0] lfsr_bits(input int n);
      logic [63:0] v;
      logic        fb;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v = {v[62:0], fb};
      end
      return v;
   endfunction

   function automatic beat_t new_beat();
      beat_t b;
      b.cmd     = CW'(lfsr_bits(CW));
      b.dstaddr = AW'(lfsr_bits(AW));
      b.srcaddr = AW'(lfsr_bits(AW));
      b.data    = DW'(lfsr_bits(DW));
      return b;
   endfunction

   // Drive at the rising edge, then model and check at the falling edge
   task automatic run_cycle(input string name, input bit offer_resp, input bit offer_req,
                            input bit rdy);
      beat_t got;
      beat_t want;
      int    g;
      bit    mready, gvalid, xfer, out_fire;
      @(posedge clk);
      if (pop_resp) void'(resp_q.pop_front());
      if (pop_req) void'(req_q.pop_front());
      if (offer_resp) resp_q.push_back(new_beat());
      if (offer_req) req_q.push_back(new_beat());
      umi_resp_in_valid <= (resp_q.size() > 0);
      if (resp_q.size() > 0)
         {umi_resp_in_cmd, umi_resp_in_dstaddr, umi_resp_in_srcaddr, umi_resp_in_data} <= resp_q[0];
      umi_req_in_valid <= (req_q.size() > 0);
      if (req_q.size() > 0)
         {umi_req_in_cmd, umi_req_in_dstaddr, umi_req_in_srcaddr, umi_req_in_data} <= req_q[0];
      umi_out_ready <= rdy;
      @(negedge clk);
      mready = (buf_cnt < 2);  // Buffer takes a beat unless both entries used
      if (lock_g != 0) g = lock_g;
      else if (relief && umi_req_in_valid) g = 2;
      else if (umi_resp_in_valid) g = 1;
      else if (umi_req_in_valid) g = 2;
      else g = 0;
      gvalid = (g == 1 && umi_resp_in_valid) || (g == 2 && umi_req_in_valid);
      xfer = gvalid && mready;
      out_fire = umi_out_valid && umi_out_ready;
      assert (umi_out_valid === (buf_cnt > 0)) else begin
         hs_errors++;
         $display("ERROR %s: out valid expected %0b, actual %0b", name, buf_cnt > 0, umi_out_valid);
      end
      assert (umi_resp_in_ready === (g == 1 && mready)) else begin
         hs_errors++;
         $display("ERROR %s: resp ready expected %0b, actual %0b", name, g == 1 && mready,
                  umi_resp_in_ready);
      end
      assert (umi_req_in_ready === (g == 2 && mready)) else begin
         hs_errors++;
         $display("ERROR %s: req ready expected %0b, actual %0b", name, g == 2 && mready,
                  umi_req_in_ready);
      end
      assert (!out_fire || exp_q.size() > 0) else begin
         hs_errors++;
         $display("An output beat left in %s while none was expected", name);
      end
      if (out_fire && exp_q.size() > 0) begin
         got = {umi_out_cmd, umi_out_dstaddr, umi_out_srcaddr, umi_out_data};
         want = exp_q.pop_front();
         assert (got === want) else begin
            cmp_errors++;
            $display("ERROR %s: expected %h, actual %h", name, want, got);
         end
      end
      pop_resp = xfer && g == 1;
      pop_req = xfer && g == 2;
      if (pop_resp) exp_q.push_back(resp_q[0]);
      if (pop_req) exp_q.push_back(req_q[0]);
      if (lock_g == 0 && gvalid && !mready) lock_g = g;  // Stalled beat keeps its grant
      else if (lock_g != 0 && xfer) lock_g = 0;
      if (xfer && g == 1 && umi_req_in_valid)
         starve_cnt = (starve_cnt == STARVE_LIMIT) ? STARVE_LIMIT : starve_cnt + 1;
      else if (xfer)
         starve_cnt = 0;
      relief = (starve_cnt == STARVE_LIMIT);
      buf_cnt = buf_cnt + int'(xfer) - int'(out_fire);
   endtask

   // Run idle cycles until every offered beat has left
   task automatic drain(input string name);
      int n;
      n = 0;
      while ((resp_q.size() != 0 || req_q.size() != 0 || exp_q.size() != 0) &&
             n < drain_limit) begin
         run_cycle(name, 1'b0, 1'b0, 1'b1);
         n++;
      end
      if (n >= drain_limit) begin
         timeouts++;
         $display("Timeout: beats of %s still pending after %0d cycles", name, drain_limit);
      end
   endtask

   initial begin
      int r, p, i;
      bit rdy;
      reset = 1'b1;
      umi_resp_in_valid = 1'b0;
      umi_req_in_valid = 1'b0;
      umi_out_ready = 1'b0;
      {umi_resp_in_cmd, umi_resp_in_dstaddr, umi_resp_in_srcaddr, umi_resp_in_data} = '0;
      {umi_req_in_cmd, umi_req_in_dstaddr, umi_req_in_srcaddr, umi_req_in_data} = '0;
      rows[0] = '{"lone_resp", 16'h0001, 16'h0000, 16'hffff, 1'b0, 1};
      rows[1] = '{"alternate", 16'h1010, 16'h0101, 16'hffff, 1'b0, 2};
      rows[2] = '{"both_valid", 16'h0001, 16'h0001, 16'hffff, 1'b0, 1};
      rows[3] = '{"starve", 16'hffff, 16'h0003, 16'hffff, 1'b0, 2};  // Second req sees restart
      rows[4] = '{"random_stall", 16'h5b6d, 16'hb6db, 16'h0000, 1'b1, 8};
      rows[5] = '{"stall_lock", 16'h0010, 16'h0007, 16'hff00, 1'b0, 1};  // Resp lands in stall
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      for (r = 0; r < 6; r++) begin
         for (p = 0; p < rows[r].reps; p++) begin
            for (i = 0; i < 16; i++) begin
               if (rows[r].rnd_rdy) rdy = (lfsr_bits(1) != 64'd0);
               else rdy = rows[r].out_rdy[i];
               run_cycle(rows[r].name, rows[r].resp_offer[i], rows[r].req_offer[i], rdy);
            end
         end
         drain(rows[r].name);
      end
      total = cmp_errors + hs_errors + timeouts +
              umi_combiner_top_inst.umi_combiner_assertions_inst.fail_count;
      $display("Errors: %0d compare, %0d handshake, %0d timeout, %0d assertion", cmp_errors,
               hs_errors, timeouts, umi_combiner_top_inst.umi_combiner_assertions_inst.fail_count);
      if (total == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/umi_combiner_assertions.sv
// Handshake checks on the top-level ports, bound into the top level, expects a held reset first
`timescale 1ns/1ps
`default_nettype none

module umi_combiner_assertions
  #(parameter int AW = umi_pkg::umi_aw_default,
    parameter int CW = umi_pkg::umi_cw_default,
    parameter int DW = umi_pkg::umi_dw_default)
   (input logic          clk,
    input logic          reset,
    input logic          umi_resp_in_ready,
    input logic          umi_req_in_valid,
    input logic          umi_req_in_ready,
    input logic [DW-1:0] umi_req_in_data,
    input logic          umi_out_valid,
    input logic [CW-1:0] umi_out_cmd,
    input logic [AW-1:0] umi_out_dstaddr,
    input logic [AW-1:0] umi_out_srcaddr,
    input logic [DW-1:0] umi_out_data,
    input logic          umi_out_ready);

   int fail_count = 0;  // Read by the testbench at the end

   // Stalled output beat holds
   out_hold: assert property (@(posedge clk) disable iff (reset)
      umi_out_valid && !umi_out_ready |=> umi_out_valid &&
      $stable({umi_out_cmd, umi_out_dstaddr, umi_out_srcaddr, umi_out_data}))
      else begin
         fail_count++;
         $error("Output beat changed while stalled");
      end

   // Pushback reaches the granted input only
   one_ready: assert property (@(posedge clk) disable iff (reset)
      !(umi_resp_in_ready && umi_req_in_ready))
      else begin
         fail_count++;
         $error("Both input readies high");
      end

   out_idle: assert property (@(posedge clk) reset |=> !umi_out_valid)
      else begin
         fail_count++;
         $error("Output valid high after reset");
      end

   // Stalled request stays offered
   req_hold: assert property (@(posedge clk) disable iff (reset)
      umi_req_in_valid && !umi_req_in_ready |=> umi_req_in_valid && $stable(umi_req_in_data))
      else begin
         fail_count++;
         $error("Stalled request beat changed");
      end

endmodule

bind umi_combiner_top umi_combiner_assertions #(.AW(AW), .CW(CW), .DW(DW))
   umi_combiner_assertions_inst (.*);

`default_nettype wire

//--- hdl/umi_combiner_top.sv
// Combiner plus output buffer on plain UMI ports, single-beat traffic with responses first
`timescale 1ns/1ps
`default_nettype none

module umi_combiner_top
  #(parameter int AW           = umi_pkg::umi_aw_default,
    parameter int CW           = umi_pkg::umi_cw_default,
    parameter int DW           = umi_pkg::umi_dw_default,
    parameter int STARVE_LIMIT = 4)
   (input  logic          clk,
    input  logic          reset,
    // Input 0, responses
    input  logic          umi_resp_in_valid,
    input  logic [CW-1:0] umi_resp_in_cmd,
    input  logic [AW-1:0] umi_resp_in_dstaddr,
    input  logic [AW-1:0] umi_resp_in_srcaddr,
    input  logic [DW-1:0] umi_resp_in_data,
    output logic          umi_resp_in_ready,
    // Input 1, requests
    input  logic          umi_req_in_valid,
    input  logic [CW-1:0] umi_req_in_cmd,
    input  logic [AW-1:0] umi_req_in_dstaddr,
    input  logic [AW-1:0] umi_req_in_srcaddr,
    input  logic [DW-1:0] umi_req_in_data,
    output logic          umi_req_in_ready,
    // Merged and registered output
    output logic          umi_out_valid,
    output logic [CW-1:0] umi_out_cmd,
    output logic [AW-1:0] umi_out_dstaddr,
    output logic [AW-1:0] umi_out_srcaddr,
    output logic [DW-1:0] umi_out_data,
    input  logic          umi_out_ready);

   umi_if #(.AW(AW), .CW(CW), .DW(DW)) resp_ch ();
   umi_if #(.AW(AW), .CW(CW), .DW(DW)) req_ch ();
   umi_if #(.AW(AW), .CW(CW), .DW(DW)) merged_ch ();  // Combiner to buffer
   umi_if #(.AW(AW), .CW(CW), .DW(DW)) out_ch ();     // Buffer to plain ports

   assign resp_ch.valid     = umi_resp_in_valid;
   assign resp_ch.cmd       = umi_resp_in_cmd;
   assign resp_ch.dstaddr   = umi_resp_in_dstaddr;
   assign resp_ch.srcaddr   = umi_resp_in_srcaddr;
   assign resp_ch.data      = umi_resp_in_data;
   assign umi_resp_in_ready = resp_ch.ready;

   assign req_ch.valid      = umi_req_in_valid;
   assign req_ch.cmd        = umi_req_in_cmd;
   assign req_ch.dstaddr    = umi_req_in_dstaddr;
   assign req_ch.srcaddr    = umi_req_in_srcaddr;
   assign req_ch.data       = umi_req_in_data;
   assign umi_req_in_ready  = req_ch.ready;

   umi_combiner #(.AW(AW), .CW(CW), .DW(DW), .STARVE_LIMIT(STARVE_LIMIT)) umi_combiner_inst (
      .clk   (clk),
      .reset (reset),
      .resp  (resp_ch.sink),
      .req   (req_ch.sink),
      .out   (merged_ch.source)
   );

   umi_out_buffer #(.AW(AW), .CW(CW), .DW(DW)) umi_out_buffer_inst (
      .clk   (clk),
      .reset (reset),
      .in    (merged_ch.sink),
      .out   (out_ch.source)
   );

   assign umi_out_valid   = out_ch.valid;
   assign umi_out_cmd     = out_ch.cmd;
   assign umi_out_dstaddr = out_ch.dstaddr;
   assign umi_out_srcaddr = out_ch.srcaddr;
   assign umi_out_data    = out_ch.data;
   assign out_ch.ready    = umi_out_ready;

endmodule

`default_nettype wire

//--- hdl/umi_out_buffer.sv
// Two-entry skid buffer with registered outputs, in-order and one cycle latency when empty
`timescale 1ns/1ps
`default_nettype none

module umi_out_buffer
  #(parameter int AW = umi_pkg::umi_aw_default,
    parameter int CW = umi_pkg::umi_cw_default,
    parameter int DW = umi_pkg::umi_dw_default)
   (input logic   clk,
    input logic   reset,
    umi_if.sink   in,
    umi_if.source out);

   logic          main_valid;  // Output register holds a beat
   logic [CW-1:0] main_cmd;
   logic [AW-1:0] main_dstaddr;
   logic [AW-1:0] main_srcaddr;
   logic [DW-1:0] main_data;
   logic          skid_valid;  // Second entry used, buffer full
   logic [CW-1:0] skid_cmd;
   logic [AW-1:0] skid_dstaddr;
   logic [AW-1:0] skid_srcaddr;
   logic [DW-1:0] skid_data;
   logic          accept;      // Input beat taken this edge
   logic          main_load;   // Output register free or draining

   assign in.ready  = !skid_valid;  // Registered, high while one entry free
   assign accept    = in.valid && !skid_valid;
   assign main_load = !main_valid || out.ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
      end else if (main_load) begin
         main_valid <= skid_valid || accept;  // Skid first, keeps order
         skid_valid <= 1'b0;
      end else if (accept) begin
         skid_valid <= 1'b1;  // Output stalled, park the beat
      end
   end

   // Payload path
   always_ff @(posedge clk) begin
      if (main_load && skid_valid) begin
         main_cmd     <= skid_cmd;
         main_dstaddr <= skid_dstaddr;
         main_srcaddr <= skid_srcaddr;
         main_data    <= skid_data;
      end else if (main_load && accept) begin
         main_cmd     <= in.cmd;
         main_dstaddr <= in.dstaddr;
         main_srcaddr <= in.srcaddr;
         main_data    <= in.data;
      end
      if (!main_load && accept) begin
         skid_cmd     <= in.cmd;
         skid_dstaddr <= in.dstaddr;
         skid_srcaddr <= in.srcaddr;
         skid_data    <= in.data;
      end
   end

   assign out.valid   = main_valid;
   assign out.cmd     = main_cmd;
   assign out.dstaddr = main_dstaddr;
   assign out.srcaddr = main_srcaddr;
   assign out.data    = main_data;

endmodule

`default_nettype wire

//--- hdl/umi_combiner.sv
// 2:1 UMI priority combiner with locked grants and starvation relief, no routing or bursts
`timescale 1ns/1ps
`default_nettype none

module umi_combiner
  #(parameter int AW           = umi_pkg::umi_aw_default,
    parameter int CW           = umi_pkg::umi_cw_default,
    parameter int DW           = umi_pkg::umi_dw_default,
    parameter int STARVE_LIMIT = 4)
   (input logic   clk,
    input logic   reset,
    umi_if.sink   resp,   // Input 0, high priority
    umi_if.sink   req,    // Input 1, low priority
    umi_if.source out);
   import umi_pkg::*;

   umi_grant_t grant;   // Owner of the merged channel
   logic       xfer;    // Merged beat transfers
   logic       relief;  // Request is overdue

   umi_arbiter umi_arbiter_inst (
      .clk        (clk),
      .reset      (reset),
      .resp_valid (resp.valid),
      .req_valid  (req.valid),
      .out_ready  (out.ready),
      .relief     (relief),
      .grant      (grant),
      .xfer       (xfer)
   );

   umi_starve_timer #(.STARVE_LIMIT(STARVE_LIMIT)) umi_starve_timer_inst (
      .clk       (clk),
      .reset     (reset),
      .xfer      (xfer),
      .req_valid (req.valid),
      .grant     (grant),
      .relief    (relief)
   );

   // Steering and pushback
   umi_mux #(.AW(AW), .CW(CW), .DW(DW)) umi_mux_inst (
      .grant (grant),
      .resp  (resp),
      .req   (req),
      .out   (out)
   );

endmodule

`default_nettype wire

//--- hdl/umi_mux.sv
// Combinational 2:1 field select by grant, ready goes back to the granted input only
`timescale 1ns/1ps
`default_nettype none

module umi_mux
  #(parameter int AW = umi_pkg::umi_aw_default,
    parameter int CW = umi_pkg::umi_cw_default,
    parameter int DW = umi_pkg::umi_dw_default)
   (input umi_pkg::umi_grant_t grant,
    umi_if.sink                resp,
    umi_if.sink                req,
    umi_if.source              out);
   import umi_pkg::*;

   logic          sel_req;  // Request owns the output
   logic [CW-1:0] sel_cmd;
   logic [AW-1:0] sel_dstaddr;
   logic [AW-1:0] sel_srcaddr;
   logic [DW-1:0] sel_data;

   assign sel_req = (grant == grant_req);

   // Fields follow the owner, resp by default when idle
   assign sel_cmd     = sel_req ? req.cmd : resp.cmd;
   assign sel_dstaddr = sel_req ? req.dstaddr : resp.dstaddr;
   assign sel_srcaddr = sel_req ? req.srcaddr : resp.srcaddr;
   assign sel_data    = sel_req ? req.data : resp.data;

   assign out.cmd     = sel_cmd;
   assign out.dstaddr = sel_dstaddr;
   assign out.srcaddr = sel_srcaddr;
   assign out.data    = sel_data;

   // No grant means no valid
   assign out.valid = (grant == grant_resp && resp.valid) || (sel_req && req.valid);

   // Flow-through pushback
   assign resp.ready = (grant == grant_resp) && out.ready;
   assign req.ready  = sel_req && out.ready;

endmodule

`default_nettype wire

//--- hdl/umi_starve_timer.sv
// Counts response wins over a waiting request, STARVE_LIMIT must be 1 or more
`timescale 1ns/1ps
`default_nettype none

module umi_starve_timer
  #(parameter int STARVE_LIMIT = 4)
   (input  logic                clk,
    input  logic                reset,
    input  logic                xfer,       // Merged transfer strobe
    input  logic                req_valid,  // Request is waiting
    input  umi_pkg::umi_grant_t grant,
    output logic                relief);    // Registered, let one request win
   import umi_pkg::*;

   localparam int cnt_w = $clog2(STARVE_LIMIT + 1);
   localparam logic [cnt_w-1:0] limit = cnt_w'(STARVE_LIMIT);

   logic [cnt_w-1:0] count;
   logic [cnt_w-1:0] count_next;

   always_comb begin
      count_next = count;
      if (xfer) begin
         if (grant == grant_resp && req_valid) begin
            // Saturate once relief is due
            count_next = (count == limit) ? limit : count + 1'b1;
         end else begin
            count_next = '0;  // Request moved or nobody was waiting
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         count  <= '0;
         relief <= 1'b0;
      end else begin
         count  <= count_next;
         relief <= (count_next == limit);  // Drops with the request transfer
      end
   end

endmodule

`default_nettype wire

//--- hdl/umi_arbiter.sv
// Fixed-priority 2:1 grant with lock under stall, assumes sources hold valid until transfer
`timescale 1ns/1ps
`default_nettype none

module umi_arbiter (
   input  logic                clk,
   input  logic                reset,
   input  logic                resp_valid,  // High priority input offering
   input  logic                req_valid,   // Low priority input offering
   input  logic                out_ready,   // Merged channel can accept
   input  logic                relief,      // Starvation timer says let req through
   output umi_pkg::umi_grant_t grant,
   output logic                xfer         // Merged beat moves this edge
);
   import umi_pkg::*;

   typedef enum logic [1:0] {
      idle,
      lock_resp,
      lock_req
   } state_t;

   state_t     state;
   state_t     state_next;
   umi_grant_t grant_idle;   // Fresh priority pick
   logic       grant_valid;  // Granted input is offering

   // Priority pick, relief lets a waiting request jump ahead once
   always_comb begin
      if (relief && req_valid) begin
         grant_idle = grant_req;
      end else if (resp_valid) begin
         grant_idle = grant_resp;
      end else if (req_valid) begin
         grant_idle = grant_req;
      end else begin
         grant_idle = grant_none;
      end
   end

   // Locked states hold the owner of a stalled beat
   always_comb begin
      case (state)
         lock_resp: grant = grant_resp;
         lock_req:  grant = grant_req;
         default:   grant = grant_idle;  // Combinational in idle
      endcase
   end

   assign grant_valid = (grant == grant_resp && resp_valid) ||
                        (grant == grant_req && req_valid);
   assign xfer = grant_valid && out_ready;  // Same as merged valid & ready

   always_comb begin
      state_next = state;
      case (state)
         idle: begin
            // Chosen beat stalls so pin the grant
            if (grant_valid && !out_ready) begin
               state_next = (grant == grant_resp) ? lock_resp : lock_req;
            end
         end
         default: begin
            if (xfer) begin
               state_next = idle;  // Stalled beat finally left
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
      end else begin
         state <= state_next;
      end
   end

endmodule

`default_nettype wire

//--- hdl/umi_if.sv
// One UMI channel of a single-beat valid/ready transfer, fields held by the source until ready
`timescale 1ns/1ps
`default_nettype none

interface umi_if
  #(parameter int AW = umi_pkg::umi_aw_default,
    parameter int CW = umi_pkg::umi_cw_default,
    parameter int DW = umi_pkg::umi_dw_default);

   logic          valid;    // Beat offered
   logic [CW-1:0] cmd;      // Command word, passed untouched
   logic [AW-1:0] dstaddr;  // Destination address
   logic [AW-1:0] srcaddr;  // Source address
   logic [DW-1:0] data;     // Payload
   logic          ready;    // Receiver can take the beat

   // Sender side
   modport source (
      output valid, cmd, dstaddr, srcaddr, data,
      input  ready
   );

   // Receiver side
   modport sink (
      input  valid, cmd, dstaddr, srcaddr, data,
      output ready
   );

endinterface

`default_nettype wire

//--- hdl/umi_pkg.sv
// Shared UMI widths and grant encoding for single-beat transactions without opcode decoding
`default_nettype none

package umi_pkg;

   // Default field widths, overridden from the top level
   localparam int umi_aw_default = 64;  // Address width
   localparam int umi_cw_default = 32;  // Command word width
   localparam int umi_dw_default = 64;  // Data width, narrowed for light simulation

   // Which input currently owns the merged channel
   typedef enum logic [1:0] {
      grant_none = 2'b00,  // Nothing offered
      grant_resp = 2'b01,  // Response input, high priority
      grant_req  = 2'b10   // Request input, low priority
   } umi_grant_t;

endpackage

`default_nettype wire
